// ==== build.f ====
source/busPkg.sv
source/fetchArbiter.sv
source/coherenceEngine.sv
source/memPortMux.sv
source/busController.sv
dv/busController_chk.sv
dv/busControllerChecker.sv
dv/busController_tb.sv

// ==== dv/busControllerChecker.sv ====
`timescale 1ns/1ps

module busControllerChecker (
    input logic                   CLK,
    input logic                   nRST,
    input busPkg::coreReq_t [1:0] cores,
    input busPkg::coreRsp_t [1:0] coreRsps,
    input busPkg::memReq_t        mem,
    input logic                   ramReady
);

    // {write, addr, data} per completed access
    logic [64:0] gotAcc [$];
    logic [64:0] expAcc [$];
    // {data side, core, word} per delivered load
    logic [33:0] gotLd [$];
    logic [33:0] expLd [$];
    int invCnt [2] = '{0, 0};
    int expInv [2] = '{0, 0};
    // block number seen with the last ccinv, and the expected one
    logic [28:0] invBlock [2] = '{29'h0, 29'h0};
    logic [28:0] expBlock [2] = '{29'h0, 29'h0};
    int testErrors = 0;
    int testCount = 0;
    int failCount = 0;

    always @(posedge CLK) begin
        if (nRST) begin
            if (ramReady && (mem.ramREN || mem.ramWEN)) begin
                gotAcc.push_back({mem.ramWEN, mem.ramaddr, mem.ramWEN ? mem.ramstore : 32'h0});
            end
            for (int c = 0; c < 2; c++) begin
                if (cores[c].iREN && !coreRsps[c].iwait) begin
                    gotLd.push_back({1'b0, c[0], coreRsps[c].iload});
                end
                // fill beats only, an upgrade carries no word
                if ((cores[c].dREN || cores[c].dWEN) && !coreRsps[c].dwait && ramReady) begin
                    gotLd.push_back({1'b1, c[0], coreRsps[c].dload});
                end
                if (coreRsps[c].ccinv) begin
                    invCnt[c]++;
                    invBlock[c] = coreRsps[c].ccsnoopaddr[31:3];
                end
            end
        end
    end

    task automatic expectAccess(input logic we, input logic [31:0] addr, input logic [31:0] data);
        expAcc.push_back({we, addr, data});
    endtask

    task automatic expectLoad(input logic isData, input int core, input logic [31:0] word);
        expLd.push_back({isData, core[0], word});
    endtask

    task automatic expectInv(input int core, input int n, input logic [31:0] addr);
        expInv[core]   = n;
        expBlock[core] = addr[31:3];
    endtask

    task automatic compareValue(input string name, input string what,
                                input logic [64:0] expected, input logic [64:0] actual);
        if (expected !== actual) begin
            testErrors++;
            $display("FAILED %s %s expected %h actual %h", name, what, expected, actual);
        end
    endtask

    task automatic finishTest(input string name);
        compareValue(name, "memory access count", expAcc.size(), gotAcc.size());
        for (int i = 0; i < expAcc.size() && i < gotAcc.size(); i++) begin
            compareValue(name, $sformatf("memory access %0d", i), expAcc[i], gotAcc[i]);
        end
        compareValue(name, "load count", expLd.size(), gotLd.size());
        for (int i = 0; i < expLd.size() && i < gotLd.size(); i++) begin
            compareValue(name, $sformatf("load %0d", i), expLd[i], gotLd[i]);
        end
        for (int c = 0; c < 2; c++) begin
            compareValue(name, $sformatf("ccinv cycles core %0d", c), expInv[c], invCnt[c]);
            if (expInv[c] != 0) begin
                compareValue(name, $sformatf("ccinv block core %0d", c),
                             {expBlock[c], 3'b000}, {invBlock[c], 3'b000});
            end
        end
        testCount++;
        if (testErrors != 0) begin
            failCount++;
            $display("%s: %0d mismatches", name, testErrors);
        end else begin
            $display("%s: ok", name);
        end
        gotAcc.delete();
        expAcc.delete();
        gotLd.delete();
        expLd.delete();
        invCnt = '{0, 0};
        expInv = '{0, 0};
        invBlock = '{29'h0, 29'h0};
        expBlock = '{29'h0, 29'h0};
        testErrors = 0;
    endtask

    task automatic summarize();
        $display("%0d tests run, %0d passed, %0d failed",
                 testCount, testCount - failCount, failCount);
    endtask

endmodule

// ==== dv/busController_chk.sv ====
`timescale 1ns/1ps

module busController_chk #(
    // snoop side checks ccinv, port side checks the data waits
    parameter bit SNOOP_SIDE = 1'b0
) (
    input logic       CLK,
    input logic       nRST,
    input logic       ramREN,
    input logic       ramWEN,
    input logic [1:0] ccwait,
    input logic [1:0] ccinv,
    input logic [1:0] dwait,
    input logic [1:0] pending
);

    int errCount = 0;

    ramExclusive: assert property (@(posedge CLK) disable iff (!nRST) !(ramREN && ramWEN))
        else begin
            errCount++;
            $error("memory read and write enabled in the same cycle");
        end

    generate
        if (SNOOP_SIDE) begin : g_snoop
            // invalidate only travels with a snoop
            invWithWait: assert property (@(posedge CLK) disable iff (!nRST)
                (ccinv & ~ccwait) == 2'b00)
                else begin
                    errCount++;
                    $error("ccinv raised without ccwait to the same core");
                end
        end else begin : g_port
            singleAck: assert property (@(posedge CLK) disable iff (!nRST)
                !(pending == 2'b11 && dwait == 2'b00))
                else begin
                    errCount++;
                    $error("both data waits low while both cores have requests pending");
                end
        end
    endgenerate

endmodule

bind memPortMux busController_chk #(.SNOOP_SIDE(1'b0)) i_chkMux (
    .CLK(CLK), .nRST(nRST), .ramREN(mem.ramREN), .ramWEN(mem.ramWEN),
    .ccwait(2'b00), .ccinv(2'b00), .dwait(dwait), .pending(dREN | dWEN)
);

bind coherenceEngine busController_chk #(.SNOOP_SIDE(1'b1)) i_chkEngine (
    .CLK(CLK), .nRST(nRST), .ramREN(engOut.req.ramREN), .ramWEN(engOut.req.ramWEN),
    .ccwait(ccwait), .ccinv(ccinv), .dwait(2'b11), .pending(2'b00)
);

// ==== dv/busController_tb.sv ====
`timescale 1ns/1ps

module busController_tb;
    import busPkg::*;

    logic                 CLK = 1'b0;
    logic                 nRST = 1'b0;
    coreReq_t [1:0]       reqDrv = '0;
    coreReq_t [1:0]       cores;
    coreRsp_t [1:0]       coreRsps;
    memReq_t              mem;
    logic [31:0]          ramload = '0;
    logic                 ramReady = 1'b0;
    logic [1:0]           snpWrite = '0;
    logic [1:0][31:0]     snpStore = '0;
    logic [31:0]          memArr [logic [31:0]];
    int                   latency = 1;
    int                   beatCnt = 0;
    logic                 peerMod = 1'b0;
    logic [31:0]          blockAddr = '0;
    logic [31:0]          wbA = '0;
    logic [31:0]          wbB = '0;
    logic [31:0]          lcgState = 32'h3efdc9b5;
    logic                 aborted = 1'b0;

    busController i_busController (
        .CLK(CLK), .nRST(nRST), .cores(cores), .coreRsps(coreRsps),
        .mem(mem), .ramload(ramload), .ramReady(ramReady)
    );

    busControllerChecker i_checker (
        .CLK(CLK), .nRST(nRST), .cores(cores), .coreRsps(coreRsps),
        .mem(mem), .ramReady(ramReady)
    );

    always #50 CLK = !CLK;

    // snoop answers override the request fields
    always_comb begin
        cores = reqDrv;
        for (int c = 0; c < 2; c++) begin
            cores[c].ccwrite = snpWrite[c];
            cores[c].dstore  = snpStore[c];
        end
    end

    function automatic logic [31:0] readWord(input logic [31:0] a);
        return memArr.exists(a) ? memArr[a] : ~a;
    endfunction

    function automatic int nextLatency();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return int'(lcgState[17:16]) + 1;
    endfunction

    // memory: ready after latency cycles, one cycle wide
    always @(posedge CLK) begin
        if (ramReady) begin
            ramReady <= 1'b0;
            beatCnt  <= 0;
            if (mem.ramWEN) begin
                memArr[mem.ramaddr] = mem.ramstore;
            end
        end else if (mem.ramREN || mem.ramWEN) begin
            if (beatCnt + 1 >= latency) begin
                ramReady <= 1'b1;
                ramload  <= readWord(mem.ramaddr);
            end else begin
                beatCnt <= beatCnt + 1;
            end
        end
    end

    // peer cache answers the snoop a cycle later
    always @(posedge CLK) begin
        for (int c = 0; c < 2; c++) begin
            snpWrite[c] <= coreRsps[c].ccwait && peerMod;
            snpStore[c] <= (coreRsps[c].ccsnoopaddr == blockAddr) ? wbA : wbB;
        end
    end

    task automatic runTest(input string name, input string kind, input int core,
                           input logic [31:0] addr, input logic [31:0] addr2, input int lat,
                           input logic [31:0] e0, input logic [31:0] e1, input logic [31:0] e2);
        int         other;
        int         dNeed;
        int         dLows;
        int         waitHigh;
        int         n;
        logic [1:0] iBusy;
        logic       dBusy;
        logic [31:0] part;
        other     = 1 - core;
        part      = addr ^ 32'h4;
        latency   = (lat == 0) ? nextLatency() : lat;
        blockAddr = addr;
        iBusy     = 2'b00;
        dBusy     = (kind == "R" || kind == "W" || kind == "U" || kind == "D");
        dNeed     = (kind == "U") ? 1 : 2;
        dLows     = 0;
        waitHigh  = 0;
        // expected traffic from the protocol rules
        if (kind == "F") begin
            i_checker.expectAccess(1'b0, addr, '0);
            i_checker.expectLoad(1'b0, core, e0);
        end else if (kind == "P") begin
            i_checker.expectAccess(1'b0, addr, '0);
            i_checker.expectAccess(1'b0, addr2, '0);
            i_checker.expectLoad(1'b0, 0, e0);
            i_checker.expectLoad(1'b0, 1, e2);
        end else begin
            if (peerMod && kind != "U") begin
                i_checker.expectAccess(1'b1, addr, wbA);
                i_checker.expectAccess(1'b1, part, wbB);
            end
            if (kind != "U") begin
                i_checker.expectAccess(1'b0, addr, '0);
                i_checker.expectAccess(1'b0, part, '0);
                i_checker.expectLoad(1'b1, core, e0);
                i_checker.expectLoad(1'b1, core, e1);
            end
            i_checker.expectInv(other, (kind == "W" || kind == "U") ? 1 : 0, addr);
            if (kind == "D") begin
                i_checker.expectAccess(1'b0, addr2, '0);
                i_checker.expectLoad(1'b0, other, e2);
            end
        end

        @(posedge CLK);
        if (kind == "F" || kind == "P") begin
            iBusy[core]         = 1'b1;
            reqDrv[core].iREN  <= 1'b1;
            reqDrv[core].iaddr <= addr;
        end
        if (kind == "P" || kind == "D") begin
            iBusy[other]         = 1'b1;
            reqDrv[other].iREN  <= 1'b1;
            reqDrv[other].iaddr <= addr2;
        end
        if (dBusy) begin
            reqDrv[core].daddr   <= addr;
            reqDrv[core].dREN    <= (kind == "R" || kind == "D");
            reqDrv[core].dWEN    <= (kind == "W" || kind == "U");
            reqDrv[core].cctrans <= (kind == "U");
        end

        n = 0;
        while ((iBusy != 2'b00 || dBusy) && n < 200) begin
            @(posedge CLK);
            n++;
            for (int c = 0; c < 2; c++) begin
                if (iBusy[c] && !coreRsps[c].iwait) begin
                    iBusy[c]          = 1'b0;
                    reqDrv[c].iREN   <= 1'b0;
                end
            end
            if (dBusy) begin
                if (coreRsps[core].dwait) begin
                    waitHigh++;
                end else begin
                    dLows++;
                    // a miss ends on the second fill beat
                    if (dLows == dNeed) begin
                        dBusy                 = 1'b0;
                        reqDrv[core].dREN    <= 1'b0;
                        reqDrv[core].dWEN    <= 1'b0;
                        reqDrv[core].cctrans <= 1'b0;
                    end
                end
            end
        end

        if (iBusy != 2'b00 || dBusy) begin
            $display("timeout: %s did not finish within 200 cycles", name);
            aborted = 1'b1;
        end else begin
            if (kind == "U") begin
                i_checker.compareValue(name, "cycles with dwait high", 3, waitHigh);
            end
            @(posedge CLK);
            i_checker.finishTest(name);
        end
    endtask

    initial begin
        int          fd;
        int          core;
        int          peer;
        int          lat;
        string       line;
        string       name;
        string       kind;
        logic [31:0] addr;
        logic [31:0] addr2;
        logic [31:0] e0;
        logic [31:0] e1;
        logic [31:0] e2;
        repeat (10) @(posedge CLK);
        nRST <= 1'b1;
        @(posedge CLK);
        fd = $fopen("dv/busController_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file");
            aborted = 1'b1;
        end
        while (!aborted && !$feof(fd)) begin
            if ($fgets(line, fd) == 0) continue;
            if (line.len() < 2 || line[0] == "#") continue;
            void'($sscanf(line, "%s", name));
            if (name == "mem") begin
                void'($sscanf(line, "%s %h %h", name, addr, e0));
                memArr[addr] = e0;
            end else begin
                void'($sscanf(line, "%s %s %d %h %h %d %h %h %d %h %h %h", name, kind, core,
                              addr, addr2, peer, wbA, wbB, lat, e0, e1, e2));
                peerMod = peer[0];
                runTest(name, kind, core, addr, addr2, lat, e0, e1, e2);
            end
        end
        i_checker.summarize();
        if (aborted || i_checker.failCount != 0 ||
            i_busController.i_memPortMux.i_chkMux.errCount != 0 ||
            i_busController.i_coherenceEngine.i_chkEngine.errCount != 0) begin
            $display("Test failed");
        end else begin
            $display("Test completed successfully");
        end
        $finish;
    end

endmodule

// ==== dv/busController_testdata.txt ====
# mem lines: mem address word
# test lines: name kind core addr addr2 peerMod wbA wbB latency exp0 exp1 exp2 (hex except core/peer/latency)
mem 00000100 11110000
mem 00000104 11110004
mem 00000200 22220000
mem 00000204 22220004
mem 00000300 33330000
mem 00000304 33330004
mem 00000400 44440000
mem 00000404 44440004
mem 00000500 55550000
mem 00000504 55550004
mem 00000600 66660000
mem 00000604 66660004
fetchCore0 F 0 00000100 0 0 0 0 2 11110000 0 0
fetchCore1 F 1 00000204 0 0 0 0 1 22220004 0 0
fetchPair P 0 00000300 00000404 0 0 0 0 33330000 0 44440004
readClean R 0 00000104 0 0 0 0 2 11110004 11110000 0
readModified R 1 00000200 0 1 aaaa0200 aaaa0204 3 aaaa0200 aaaa0204 0
writeMiss W 0 00000304 0 0 0 0 1 33330004 33330000 0
writeMissModified W 1 00000400 0 1 bbbb0400 bbbb0404 2 bbbb0400 bbbb0404 0
upgrade U 0 00000500 0 0 0 0 1 0 0 0
dataOverFetch D 0 00000600 00000504 0 0 0 0 66660000 66660004 55550004
dataOverFetch1 D 1 00000104 00000100 0 0 0 0 11110004 11110000 11110000

// ==== source/busController.sv ====
`timescale 1ns/1ps

module busController #(
    parameter int ADDR_W = busPkg::addrWidth,
    parameter int DATA_W = busPkg::dataWidth
) (
    input  logic                   CLK,
    input  logic                   nRST,
    input  busPkg::coreReq_t [1:0] cores,
    output busPkg::coreRsp_t [1:0] coreRsps,
    output busPkg::memReq_t        mem,
    input  logic [DATA_W-1:0]      ramload,
    input  logic                   ramReady
);
    import busPkg::*;

    memReq_t                fetchReq;
    engineOut_t             engOut;
    logic                   fetchCore;
    logic                   fetchDone;
    logic                   beatDone;
    logic [1:0]             iREN;
    logic [1:0]             dREN;
    logic [1:0]             dWEN;
    logic [1:0]             iwait;
    logic [1:0]             dwait;
    logic [1:0]             ccwait;
    logic [1:0]             ccinv;
    logic [1:0][ADDR_W-1:0] iaddr;
    logic [1:0][ADDR_W-1:0] ccsnoopaddr;
    logic [1:0][DATA_W-1:0] iload;
    logic [1:0][DATA_W-1:0] dload;

    // unpack requests, pack responses
    always_comb begin
        for (int c = 0; c < 2; c++) begin
            iREN[c]  = cores[c].iREN;
            iaddr[c] = cores[c].iaddr;
            dREN[c]  = cores[c].dREN;
            dWEN[c]  = cores[c].dWEN;
            coreRsps[c].iwait       = iwait[c];
            coreRsps[c].iload       = iload[c];
            coreRsps[c].dwait       = dwait[c];
            coreRsps[c].dload       = dload[c];
            coreRsps[c].ccwait      = ccwait[c];
            coreRsps[c].ccinv       = ccinv[c];
            coreRsps[c].ccsnoopaddr = ccsnoopaddr[c];
        end
    end

    fetchArbiter #(
        .ADDR_W(ADDR_W),
        .DATA_W(DATA_W)
    ) i_fetchArbiter (
        .CLK       (CLK),
        .nRST      (nRST),
        .iREN      (iREN),
        .iaddr     (iaddr),
        .fetchDone (fetchDone),
        .fetchReq  (fetchReq),
        .fetchCore (fetchCore)
    );

    coherenceEngine #(
        .ADDR_W(ADDR_W),
        .DATA_W(DATA_W)
    ) i_coherenceEngine (
        .CLK         (CLK),
        .nRST        (nRST),
        .cores       (cores),
        .beatDone    (beatDone),
        .engOut      (engOut),
        .ccwait      (ccwait),
        .ccinv       (ccinv),
        .ccsnoopaddr (ccsnoopaddr)
    );

    memPortMux #(
        .ADDR_W(ADDR_W),
        .DATA_W(DATA_W)
    ) i_memPortMux (
        .CLK       (CLK),
        .nRST      (nRST),
        .engOut    (engOut),
        .fetchReq  (fetchReq),
        .fetchCore (fetchCore),
        .iREN      (iREN),
        .dREN      (dREN),
        .dWEN      (dWEN),
        .ramload   (ramload),
        .ramReady  (ramReady),
        .mem       (mem),
        .fetchDone (fetchDone),
        .beatDone  (beatDone),
        .iwait     (iwait),
        .dwait     (dwait),
        .iload     (iload),
        .dload     (dload)
    );

endmodule

// ==== source/busPkg.sv ====
package busPkg;

    localparam int addrWidth = 32;
    localparam int dataWidth = 32;

    // two-word blocks of four-byte words
    localparam int byteOffWidth = 2;
    localparam int indexWidth = 3;
    localparam int tagWidth = addrWidth - indexWidth - 1 - byteOffWidth;

    // one address word, also seen as cache fields
    typedef union packed {
        logic [addrWidth-1:0] word;
        struct packed {
            logic [tagWidth-1:0]     tag;
            logic [indexWidth-1:0]   index;
            logic                    blockOff;
            logic [byteOffWidth-1:0] byteOff;
        } fields;
    } busAddr_t;

    // cache to controller, one per core
    typedef struct packed {
        logic                 iREN;
        logic [addrWidth-1:0] iaddr;
        logic                 dREN;
        logic                 dWEN;
        logic [addrWidth-1:0] daddr;
        logic [dataWidth-1:0] dstore;
        logic                 cctrans;
        logic                 ccwrite;
    } coreReq_t;

    // controller to cache, one per core
    typedef struct packed {
        logic                 iwait;
        logic [dataWidth-1:0] iload;
        logic                 dwait;
        logic [dataWidth-1:0] dload;
        logic                 ccwait;
        logic                 ccinv;
        logic [addrWidth-1:0] ccsnoopaddr;
    } coreRsp_t;

    typedef struct packed {
        logic                 ramREN;
        logic                 ramWEN;
        logic [addrWidth-1:0] ramaddr;
        logic [dataWidth-1:0] ramstore;
    } memReq_t;

    // engine to port mux
    typedef struct packed {
        memReq_t req;
        logic    core;
        // requester's dwait may drop when this beat completes
        logic    doneBeat;
    } engineOut_t;

    typedef enum logic [3:0] {
        stIdle,
        stSnoop,
        stCheck,
        stWb1,
        stWb2,
        stInv,
        stFill1,
        stFill2
    } busState_t;

endpackage

// ==== source/coherenceEngine.sv ====
`timescale 1ns/1ps

module coherenceEngine #(
    parameter int ADDR_W = busPkg::addrWidth,
    parameter int DATA_W = busPkg::dataWidth
) (
    input  logic                   CLK,
    input  logic                   nRST,
    input  busPkg::coreReq_t [1:0] cores,
    input  logic                   beatDone,
    output busPkg::engineOut_t     engOut,
    output logic [1:0]             ccwait,
    output logic [1:0]             ccinv,
    output logic [1:0][ADDR_W-1:0] ccsnoopaddr
);
    import busPkg::*;

    busState_t state;
    busState_t nextState;

    // transaction held for its whole life
    logic reqCore;
    logic isWrite;
    logic isUpgrade;

    // peer's word for the requested address, taken at the end of the check cycle
    logic [DATA_W-1:0] wbData;

    logic     peer;
    logic     startReq;
    logic     startCore;
    logic     startWrite;
    busAddr_t reqAddr;
    busAddr_t partnerAddr;

    // pick a new request: reads first, then core 0 before core 1
    always_comb begin
        startReq   = 1'b1;
        startCore  = 1'b0;
        startWrite = 1'b0;
        if (cores[0].dREN) begin
            startCore = 1'b0;
        end else if (cores[1].dREN) begin
            startCore = 1'b1;
        end else if (cores[0].dWEN) begin
            startCore  = 1'b0;
            startWrite = 1'b1;
        end else if (cores[1].dWEN) begin
            startCore  = 1'b1;
            startWrite = 1'b1;
        end else begin
            startReq = 1'b0;
        end
    end

    assign peer    = !reqCore;
    assign reqAddr = cores[reqCore].daddr;

    // other word of the block
    always_comb begin
        partnerAddr = reqAddr;
        partnerAddr.fields.blockOff = !reqAddr.fields.blockOff;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= stIdle;
            reqCore   <= 1'b0;
            isWrite   <= 1'b0;
            isUpgrade <= 1'b0;
        end else begin
            state <= nextState;
            if (state == stIdle && startReq) begin
                reqCore <= startCore;
                isWrite <= startWrite;
                // requester already holds the block shared
                isUpgrade <= startWrite && cores[startCore].cctrans;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (state == stCheck) begin
            wbData <= cores[peer].dstore;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            stIdle: begin
                if (startReq) begin
                    nextState = stSnoop;
                end
            end
            stSnoop: begin
                nextState = stCheck;
            end
            stCheck: begin
                // peer answer to the snoop is valid now
                if (cores[peer].ccwrite && !isUpgrade) begin
                    nextState = stWb1;
                end else if (isWrite) begin
                    nextState = stInv;
                end else begin
                    nextState = stFill1;
                end
            end
            stWb1: begin
                if (beatDone) begin
                    nextState = stWb2;
                end
            end
            stWb2: begin
                if (beatDone) begin
                    nextState = isWrite ? stInv : stFill1;
                end
            end
            stInv: begin
                nextState = isUpgrade ? stIdle : stFill1;
            end
            stFill1: begin
                if (beatDone) begin
                    nextState = stFill2;
                end
            end
            stFill2: begin
                if (beatDone) begin
                    nextState = stIdle;
                end
            end
            default: begin
                nextState = stIdle;
            end
        endcase
    end

    always_comb begin
        engOut      = '0;
        engOut.core = reqCore;
        ccwait      = '0;
        ccinv       = '0;
        ccsnoopaddr = '0;
        case (state)
            stSnoop: begin
                ccwait[peer]      = 1'b1;
                ccsnoopaddr[peer] = reqAddr.word;
            end
            stCheck: begin
                // ask for the partner word while the first answer is sampled
                ccwait[peer]      = 1'b1;
                ccsnoopaddr[peer] = partnerAddr.word;
            end
            stWb1: begin
                ccwait[peer]           = 1'b1;
                ccsnoopaddr[peer]      = partnerAddr.word;
                engOut.req.ramWEN   = 1'b1;
                engOut.req.ramaddr  = reqAddr.word;
                engOut.req.ramstore = wbData;
            end
            stWb2: begin
                ccwait[peer]           = 1'b1;
                ccsnoopaddr[peer]      = partnerAddr.word;
                engOut.req.ramWEN   = 1'b1;
                engOut.req.ramaddr  = partnerAddr.word;
                engOut.req.ramstore = cores[peer].dstore;
            end
            stInv: begin
                ccwait[peer]      = 1'b1;
                ccinv[peer]       = 1'b1;
                ccsnoopaddr[peer] = partnerAddr.word;
                // an upgrade ends here without memory traffic
                engOut.doneBeat   = isUpgrade;
            end
            stFill1: begin
                engOut.req.ramREN  = 1'b1;
                engOut.req.ramaddr = reqAddr.word;
                engOut.doneBeat    = 1'b1;
            end
            stFill2: begin
                engOut.req.ramREN  = 1'b1;
                engOut.req.ramaddr = partnerAddr.word;
                engOut.doneBeat    = 1'b1;
            end
            default: begin
                engOut.doneBeat = 1'b0;
            end
        endcase
    end

endmodule

// ==== source/fetchArbiter.sv ====
`timescale 1ns/1ps

module fetchArbiter #(
    parameter int ADDR_W = busPkg::addrWidth,
    parameter int DATA_W = busPkg::dataWidth
) (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic [1:0]             iREN,
    input  logic [1:0][ADDR_W-1:0] iaddr,
    input  logic                   fetchDone,
    output busPkg::memReq_t        fetchReq,
    output logic                   fetchCore
);

    logic active;
    logic activeCore;

    // grant is registered and held until the word comes back
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            active     <= 1'b0;
            activeCore <= 1'b0;
        end else if (active) begin
            if (fetchDone) begin
                active <= 1'b0;
            end
        end else if (|iREN) begin
            active <= 1'b1;
            // core 0 wins a tie
            activeCore <= !iREN[0];
        end
    end

    assign fetchCore = activeCore;

    // fetches are always single-word reads
    always_comb begin
        fetchReq.ramREN   = active;
        fetchReq.ramWEN   = 1'b0;
        fetchReq.ramaddr  = iaddr[activeCore];
        fetchReq.ramstore = {DATA_W{1'b0}};
    end

endmodule

// ==== source/memPortMux.sv ====
`timescale 1ns/1ps

module memPortMux #(
    parameter int ADDR_W = busPkg::addrWidth,
    parameter int DATA_W = busPkg::dataWidth
) (
    input  logic                   CLK,
    input  logic                   nRST,
    input  busPkg::engineOut_t     engOut,
    input  busPkg::memReq_t        fetchReq,
    input  logic                   fetchCore,
    input  logic [1:0]             iREN,
    input  logic [1:0]             dREN,
    input  logic [1:0]             dWEN,
    input  logic [DATA_W-1:0]      ramload,
    input  logic                   ramReady,
    output busPkg::memReq_t        mem,
    output logic                   fetchDone,
    output logic                   beatDone,
    output logic [1:0]             iwait,
    output logic [1:0]             dwait,
    output logic [1:0][DATA_W-1:0] iload,
    output logic [1:0][DATA_W-1:0] dload
);

    // side holding the port until ramReady
    logic ownerValid;
    logic ownerData;

    logic              dataPending;
    logic              dataWants;
    logic              fetchWants;
    logic              grantData;
    logic              grantFetch;
    logic              dataAck;
    logic [ADDR_W-1:0] grantAddr;

    assign dataPending = |(dREN | dWEN);
    assign dataWants   = engOut.req.ramREN | engOut.req.ramWEN;
    assign fetchWants  = fetchReq.ramREN;

    always_comb begin
        if (ownerValid) begin
            grantData  = ownerData;
            grantFetch = !ownerData;
        end else begin
            grantData = dataWants;
            // any pending data request keeps an unstarted fetch off the port
            grantFetch = fetchWants && !dataPending;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ownerValid <= 1'b0;
            ownerData  <= 1'b0;
        end else if (ramReady) begin
            ownerValid <= 1'b0;
        end else if (!ownerValid && (grantData || grantFetch)) begin
            ownerValid <= 1'b1;
            ownerData  <= grantData;
        end
    end

    assign grantAddr = grantData ? engOut.req.ramaddr : fetchReq.ramaddr;

    always_comb begin
        mem         = '0;
        mem.ramaddr = grantAddr;
        if (grantData) begin
            mem.ramREN   = engOut.req.ramREN;
            mem.ramWEN   = engOut.req.ramWEN;
            mem.ramstore = engOut.req.ramstore;
        end else if (grantFetch) begin
            mem.ramREN = 1'b1;
        end
    end

    assign fetchDone = grantFetch && ramReady;
    assign beatDone  = grantData && ramReady;

    // fill beats finish on ramReady, an upgrade finishes at once
    assign dataAck = engOut.doneBeat && (beatDone || !dataWants);

    always_comb begin
        for (int c = 0; c < 2; c++) begin
            iload[c] = (fetchCore == c[0]) ? ramload : '0;
            dload[c] = (engOut.core == c[0]) ? ramload : '0;
            iwait[c] = iREN[c] && !(fetchDone && fetchCore == c[0]);
            dwait[c] = (dREN[c] || dWEN[c]) && !(dataAck && engOut.core == c[0]);
        end
    end

endmodule
